/* files.f */
logic/mips_pkg.sv
logic/mips_fetch.sv
logic/mips_decode.sv
logic/mips_hazard.sv
logic/mips_execute.sv
logic/mips_memory.sv
logic/mips_top.sv
tests/tb_clock.sv
tests/mips_assert.sv
tests/mips_tb.sv

/* tests/mips_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_tb;
	import mips_pkg::*;

	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;
	localparam int MAX_WB     = 256;
	// Three directed programs, then three random ones
	localparam int NUM_PROGS  = 6;

	logic                  clk;
	logic                  arst_n;
	logic                  load_en;
	logic [DATA_W-1:0]     load_data;
	logic                  wb_en;
	logic [REG_ADDR_W-1:0] wb_addr;
	logic [DATA_W-1:0]     wb_data;

	// Program image and the model's writeback sequence
	instr_u                prog [IMEM_DEPTH];
	int                    prog_len;
	logic [REG_ADDR_W-1:0] exp_addr [MAX_WB];
	logic [DATA_W-1:0]     exp_data [MAX_WB];
	int                    exp_count = 0;
	int                    wb_idx;
	logic [31:0]           lcg_state;
	int                    cycle_count = 0;
	int                    cycle_limit = 0;

	tb_clock #(.PERIOD_NS(100)) clock_inst (.clk(clk));

	mips_top #(
		.IMEM_DEPTH(IMEM_DEPTH),
		.DMEM_DEPTH(DMEM_DEPTH)
	) mips_top_inst (
		.clk(clk),
		.arst_n(arst_n),
		.load_en(load_en),
		.load_data(load_data),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

	bind mips_top mips_assert mips_assert_inst (.*);

	// ------------------------------
	// Assembler
	// ------------------------------
	function automatic instr_u r_form(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		instr_u w;
		w          = '0;
		w.r.opcode = OP_RTYPE;
		w.r.rs     = rs;
		w.r.rt     = rt;
		w.r.rd     = rd;
		w.r.funct  = funct;
		return w;
	endfunction

	// rt is the destination for ADDI and LW, the data for SW
	function automatic instr_u i_form(input logic [5:0] opcode, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		instr_u w;
		w.i.opcode = opcode;
		w.i.rs     = rs;
		w.i.rt     = rt;
		w.i.imm    = imm;
		return w;
	endfunction

	// Target is a word index in the low 26 bits
	function automatic instr_u jump_to(input int word);
		instr_u w;
		w                       = '0;
		w.i.opcode              = OP_J;
		{w.i.rs, w.i.rt, w.i.imm} = word[25:0];
		return w;
	endfunction

	task automatic emit(input instr_u w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// One of r1..r7
	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = next_rand();
		return 5'(1 + r[31:16] % 7);
	endfunction

	// ------------------------------
	// Programs
	// ------------------------------
	task automatic build_program(input int p);
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic [4:0]  rt;
		prog_len = 0;
		case (p)
			0: begin
				// Dependent chains, then writes to $0
				emit(i_form(OP_ADDI, 5'd0, 5'd1, 16'd5));
				emit(i_form(OP_ADDI, 5'd1, 5'd2, 16'd3));
				emit(r_form(FN_ADD, 5'd3, 5'd1, 5'd2));
				emit(r_form(FN_SUB, 5'd4, 5'd3, 5'd1));
				emit(r_form(FN_AND, 5'd5, 5'd4, 5'd3));
				emit(r_form(FN_OR, 5'd6, 5'd5, 5'd1));
				emit(r_form(FN_SLT, 5'd7, 5'd1, 5'd3));
				emit(r_form(FN_SLT, 5'd8, 5'd3, 5'd1));
				emit(i_form(OP_ADDI, 5'd1, 5'd0, 16'd7));
				emit(r_form(FN_ADD, 5'd9, 5'd0, 5'd2));
				emit(i_form(OP_ADDI, 5'd0, 5'd10, 16'hfff7));
				emit(r_form(FN_SLT, 5'd11, 5'd10, 5'd1));
				emit(r_form(FN_ADD, 5'd0, 5'd10, 5'd10));
				emit(r_form(FN_OR, 5'd12, 5'd0, 5'd10));
			end
			1: begin
				// Store, load, load-use consumers
				emit(i_form(OP_ADDI, 5'd0, 5'd1, 16'd40));
				emit(i_form(OP_ADDI, 5'd0, 5'd2, 16'd123));
				emit(i_form(OP_SW, 5'd1, 5'd2, 16'd0));
				emit(i_form(OP_LW, 5'd1, 5'd3, 16'd0));
				emit(r_form(FN_ADD, 5'd4, 5'd3, 5'd3));
				emit(i_form(OP_SW, 5'd1, 5'd4, 16'd4));
				emit(i_form(OP_LW, 5'd1, 5'd5, 16'd4));
				emit(i_form(OP_ADDI, 5'd5, 5'd6, 16'd1));
				emit(i_form(OP_LW, 5'd1, 5'd7, 16'd0));
				// Branch right behind a load, taken
				emit(i_form(OP_BEQ, 5'd7, 5'd2, 16'd1));
				emit(i_form(OP_ADDI, 5'd0, 5'd8, 16'd111));
				emit(i_form(OP_ADDI, 5'd7, 5'd9, 16'd9));
			end
			2: begin
				emit(i_form(OP_ADDI, 5'd0, 5'd1, 16'd1));
				emit(i_form(OP_ADDI, 5'd0, 5'd2, 16'd1));
				emit(i_form(OP_BEQ, 5'd1, 5'd2, 16'd1));
				emit(i_form(OP_ADDI, 5'd0, 5'd10, 16'd77));
				emit(i_form(OP_ADDI, 5'd0, 5'd3, 16'd3));
				// Not taken, operand from the instruction before
				emit(i_form(OP_BEQ, 5'd3, 5'd1, 16'd5));
				emit(i_form(OP_ADDI, 5'd0, 5'd4, 16'd4));
				emit(r_form(FN_SUB, 5'd5, 5'd4, 5'd3));
				emit(i_form(OP_BEQ, 5'd5, 5'd1, 16'd2));
				emit(i_form(OP_ADDI, 5'd0, 5'd11, 16'd88));
				emit(i_form(OP_ADDI, 5'd0, 5'd12, 16'd99));
				emit(jump_to(14));
				emit(i_form(OP_ADDI, 5'd0, 5'd13, 16'd66));
				emit(i_form(OP_ADDI, 5'd0, 5'd14, 16'd55));
				emit(i_form(OP_ADDI, 5'd0, 5'd6, 16'd6));
				emit(i_form(OP_BEQ, 5'd0, 5'd0, 16'd1));
				emit(i_form(OP_ADDI, 5'd0, 5'd15, 16'd44));
			end
			default: begin
				for (int n = 0; n < 40; n++) begin
					rd = pick_reg();
					rs = pick_reg();
					rt = pick_reg();
					r  = next_rand();
					case (r[31:16] % 6)
						0:       emit(r_form(FN_ADD, rd, rs, rt));
						1:       emit(r_form(FN_SUB, rd, rs, rt));
						2:       emit(r_form(FN_AND, rd, rs, rt));
						3:       emit(r_form(FN_OR, rd, rs, rt));
						4:       emit(r_form(FN_SLT, rd, rs, rt));
						default: emit(i_form(OP_ADDI, rs, rd, r[15:0]));
					endcase
				end
			end
		endcase
		// Jump to self ends every program
		emit(jump_to(prog_len));
	endtask

	// ------------------------------
	// Reference model
	// ------------------------------
	task automatic run_model();
		logic [DATA_W-1:0] regs [NUM_REGS];
		logic [DATA_W-1:0] mem [DMEM_DEPTH];
		logic [DATA_W-1:0] pc;
		logic [DATA_W-1:0] pc4;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] imm;
		logic [DATA_W-1:0] addr;
		logic [DATA_W-1:0] val;
		logic [4:0]        dest;
		logic              writes;
		logic              halted;
		instr_u            w;
		int                steps;
		for (int i = 0; i < NUM_REGS; i++) begin
			regs[i] = '0;
		end
		pc        = '0;
		halted    = 1'b0;
		steps     = 0;
		exp_count = 0;
		while (!halted && steps < 200) begin
			w      = prog[pc[7:2]];
			a      = regs[w.r.rs];
			b      = regs[w.r.rt];
			imm    = {{16{w.i.imm[15]}}, w.i.imm};
			addr   = a + imm;
			pc4    = pc + 32'd4;
			dest   = w.r.rt;
			val    = '0;
			writes = 1'b0;
			pc     = pc4;
			case (w.r.opcode)
				OP_RTYPE: begin
					writes = 1'b1;
					dest   = w.r.rd;
					case (w.r.funct)
						FN_ADD:  val = a + b;
						FN_SUB:  val = a - b;
						FN_AND:  val = a & b;
						FN_OR:   val = a | b;
						default: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					endcase
				end
				OP_ADDI: begin
					writes = 1'b1;
					val    = addr;
				end
				OP_LW: begin
					writes = 1'b1;
					val    = mem[addr[7:2]];
				end
				OP_SW:   mem[addr[7:2]] = b;
				// No delay slot, the next instruction is squashed
				OP_BEQ: begin
					if (a == b) begin
						pc = pc4 + {imm[29:0], 2'b00};
					end
				end
				OP_J: begin
					pc = {pc4[31:28], w.i.rs, w.i.rt, w.i.imm, 2'b00};
					halted = (pc == pc4 - 32'd4);
				end
				default: ;
			endcase
			if (writes && dest != '0) begin
				regs[dest]          = val;
				exp_addr[exp_count] = dest;
				exp_data[exp_count] = val;
				exp_count++;
			end
			steps++;
		end
	endtask

	// ------------------------------
	// Stimulus
	// ------------------------------
	task automatic run_program();
		@(posedge clk);
		#1;
		arst_n  = 1'b0;
		load_en = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		// Loading starts with the reset release
		arst_n    = 1'b1;
		load_en   = 1'b1;
		load_data = prog[0];
		for (int n = 1; n < prog_len; n++) begin
			@(posedge clk);
			#1;
			load_data = prog[n];
		end
		@(posedge clk);
		#1;
		load_en = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (wb_idx < exp_count);
		// Room for a stray strobe after the last result
		repeat (4) @(posedge clk);
	endtask

	// ------------------------------
	// Checks
	// ------------------------------
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_idx <= 0;
		end else if (wb_en) begin
			wb_idx <= wb_idx + 1;
		end
	end

	extra_wb_check: assert property (@(posedge clk) disable iff (!arst_n)
		wb_en |-> wb_idx < exp_count)
		else begin
			$display("error %0t: unexpected writeback r%0d = %h after %0d results",
				$time, $sampled(wb_addr), $sampled(wb_data), exp_count);
			$display("TEST FAIL");
			$fatal(1);
		end

	wb_value_check: assert property (@(posedge clk) disable iff (!arst_n)
		wb_en && wb_idx < exp_count |->
		wb_addr == exp_addr[wb_idx] && wb_data == exp_data[wb_idx])
		else begin
			$display("error %0t: writeback %0d is r%0d = %h, expected r%0d = %h",
				$time, $sampled(wb_idx), $sampled(wb_addr), $sampled(wb_data),
				exp_addr[$sampled(wb_idx)], exp_data[$sampled(wb_idx)]);
			$display("TEST FAIL");
			$fatal(1);
		end

	// Protocol properties live in the bound checker
	always @(negedge clk) begin
		if (mips_top_inst.mips_assert_inst.fired) begin
			$display("a protocol assertion in mips_assert failed");
			$display("TEST FAIL");
			$fatal(1);
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the run hung after %0d cycles", cycle_count);
			$display("TEST FAIL");
			$fatal(1);
		end
	end

	initial begin
		arst_n    = 1'b0;
		load_en   = 1'b0;
		load_data = '0;
		lcg_state = 32'h2508;
		for (int p = 0; p < NUM_PROGS; p++) begin
			build_program(p);
			run_model();
			cycle_limit = cycle_limit + 16 + prog_len + 3 * prog_len + 8;
			run_program();
		end
		if (mips_top_inst.mips_assert_inst.fired) begin
			$display("TEST FAIL");
			$fatal(1);
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tests/mips_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_assert (
	input wire                             clk,
	input wire                             arst_n,
	input wire                             load_en,
	input wire                             stall,
	input wire                             redirect,
	input wire                             wb_en,
	input wire [mips_pkg::REG_ADDR_W-1:0]  wb_addr
);

	// Sticky, set by any failing property below
	logic fired = 1'b0;

	// ------------------------------
	// Reset and loading
	// ------------------------------
	// Nothing retires, stalls or redirects while reset is held
	reset_quiet: assert property (@(posedge clk)
		!arst_n |-> !wb_en && !stall && !redirect)
		else begin
			fired = 1'b1;
			$error("pipeline active while reset is asserted");
		end

	// Core issues nothing during loading
	load_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		load_en |-> !wb_en)
		else begin
			fired = 1'b1;
			$error("writeback strobe while the program is loading");
		end

	// First fetch is one cycle after loading, then four stages to writeback
	start_gap: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(load_en) |-> !wb_en [*4])
		else begin
			fired = 1'b1;
			$error("writeback strobe earlier than four cycles after loading");
		end

	// ------------------------------
	// Writeback port
	// ------------------------------
	// $0 writes are dropped in decode
	no_zero_write: assert property (@(posedge clk) disable iff (!arst_n)
		wb_en |-> wb_addr != '0)
		else begin
			fired = 1'b1;
			$error("writeback strobe addresses register 0");
		end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 100
) (
	output logic clk
);

	// Free-running clock, starts low
	initial begin
		clk = 1'b0;
	end

	always begin
		#(PERIOD_NS / 2);
		clk = ~clk;
	end

endmodule

`default_nettype wire

/* logic/mips_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_top #(
	parameter int IMEM_DEPTH = 64,
	parameter int DMEM_DEPTH = 64
) (
	input  wire                              clk,
	input  wire                              arst_n,
	input  wire                              load_en,
	input  wire [mips_pkg::DATA_W-1:0]       load_data,
	output wire                              wb_en,
	output wire [mips_pkg::REG_ADDR_W-1:0]   wb_addr,
	output wire [mips_pkg::DATA_W-1:0]       wb_data
);
	import mips_pkg::*;

	// ------------------------------
	// Fetch and decode
	// ------------------------------
	instr_u                instr_d;
	logic [DATA_W-1:0]     pc_plus4_d;
	logic [DATA_W-1:0]     redirect_pc;
	logic                  redirect;
	logic [REG_ADDR_W-1:0] rs_d, rt_d;
	logic                  branch_d;

	// Hazard controls
	logic [1:0]            fwd_a_e, fwd_b_e;
	logic                  fwd_a_d, fwd_b_d;
	logic                  stall, flush_e;

	// ------------------------------
	// Execute and memory
	// ------------------------------
	logic [REG_ADDR_W-1:0] rs_e, rt_e, rd_e;
	logic [DATA_W-1:0]     read_a_e, read_b_e, imm_e;
	logic [2:0]            alu_op_e;
	logic                  alu_src_e, reg_dst_e, reg_write_e;
	logic                  mem_to_reg_e, mem_write_e;
	logic [REG_ADDR_W-1:0] write_reg_e, write_reg_m;
	logic [DATA_W-1:0]     alu_result_m, store_data_m;
	logic                  reg_write_m, mem_to_reg_m, mem_write_m;

	// Every port name matches its net
	mips_fetch #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_inst (.*);

	mips_decode decode_inst (.*);

	mips_hazard hazard_inst (.*);

	mips_execute execute_inst (.*);

	mips_memory #(.DMEM_DEPTH(DMEM_DEPTH)) memory_inst (.*);

endmodule

`default_nettype wire

/* logic/mips_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_memory #(
	parameter int DMEM_DEPTH = 64
) (
	input  wire                               clk,
	input  wire                               arst_n,
	input  wire  [mips_pkg::DATA_W-1:0]       alu_result_m,
	input  wire  [mips_pkg::DATA_W-1:0]       store_data_m,
	input  wire  [mips_pkg::REG_ADDR_W-1:0]   write_reg_m,
	input  wire                               reg_write_m,
	input  wire                               mem_to_reg_m,
	input  wire                               mem_write_m,
	output logic                              wb_en,
	output logic [mips_pkg::REG_ADDR_W-1:0]   wb_addr,
	output logic [mips_pkg::DATA_W-1:0]       wb_data
);
	import mips_pkg::*;

	localparam int DA_W = $clog2(DMEM_DEPTH);

	logic [DATA_W-1:0] dmem [DMEM_DEPTH];
	logic [DATA_W-1:0] read_data_m;
	logic [DATA_W-1:0] read_data_w;
	logic [DATA_W-1:0] alu_result_w;
	logic              mem_to_reg_w;

	// Word addressed, byte offset ignored
	assign read_data_m = dmem[alu_result_m[DA_W+1:2]];

	always_ff @(posedge clk) begin
		if (mem_write_m) begin
			dmem[alu_result_m[DA_W+1:2]] <= store_data_m;
		end
	end

	// ------------------------------
	// Memory/writeback register
	// ------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_en        <= 1'b0;
			wb_addr      <= '0;
			mem_to_reg_w <= 1'b0;
		end else begin
			wb_en        <= reg_write_m;
			wb_addr      <= write_reg_m;
			mem_to_reg_w <= mem_to_reg_m;
		end
	end

	always_ff @(posedge clk) begin
		read_data_w  <= read_data_m;
		alu_result_w <= alu_result_m;
	end

	// Result select
	assign wb_data = mem_to_reg_w ? read_data_w : alu_result_w;

endmodule

`default_nettype wire

/* logic/mips_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_execute (
	input  wire                               clk,
	input  wire                               arst_n,
	input  wire  [mips_pkg::REG_ADDR_W-1:0]   rt_e,
	input  wire  [mips_pkg::REG_ADDR_W-1:0]   rd_e,
	input  wire  [mips_pkg::DATA_W-1:0]       read_a_e,
	input  wire  [mips_pkg::DATA_W-1:0]       read_b_e,
	input  wire  [mips_pkg::DATA_W-1:0]       imm_e,
	input  wire  [2:0]                        alu_op_e,
	input  wire                               alu_src_e,
	input  wire                               reg_dst_e,
	input  wire                               reg_write_e,
	input  wire                               mem_to_reg_e,
	input  wire                               mem_write_e,
	input  wire  [1:0]                        fwd_a_e,
	input  wire  [1:0]                        fwd_b_e,
	input  wire  [mips_pkg::DATA_W-1:0]       wb_data,
	output logic [mips_pkg::REG_ADDR_W-1:0]   write_reg_e,
	output logic [mips_pkg::DATA_W-1:0]       alu_result_m,
	output logic [mips_pkg::DATA_W-1:0]       store_data_m,
	output logic [mips_pkg::REG_ADDR_W-1:0]   write_reg_m,
	output logic                              reg_write_m,
	output logic                              mem_to_reg_m,
	output logic                              mem_write_m
);
	import mips_pkg::*;

	logic [DATA_W-1:0] src_a;
	logic [DATA_W-1:0] src_b;
	logic [DATA_W-1:0] alu_b;
	logic [DATA_W-1:0] alu_y;

	// ------------------------------
	// Operand select
	// ------------------------------
	always_comb begin
		case (fwd_a_e)
			FWD_MEM: src_a = alu_result_m;
			FWD_WB:  src_a = wb_data;
			default: src_a = read_a_e;
		endcase
		case (fwd_b_e)
			FWD_MEM: src_b = alu_result_m;
			FWD_WB:  src_b = wb_data;
			default: src_b = read_b_e;
		endcase
	end

	// Forwarded rt doubles as store data
	assign alu_b = alu_src_e ? imm_e : src_b;

	always_comb begin
		case (alu_op_e)
			ALU_SUB: alu_y = src_a - alu_b;
			ALU_AND: alu_y = src_a & alu_b;
			ALU_OR:  alu_y = src_a | alu_b;
			ALU_SLT: alu_y = DATA_W'($signed(src_a) < $signed(alu_b));
			default: alu_y = src_a + alu_b;
		endcase
	end

	// R-type writes rd, immediate forms write rt
	assign write_reg_e = reg_dst_e ? rd_e : rt_e;

	// ------------------------------
	// Execute/memory register
	// ------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			write_reg_m  <= '0;
			reg_write_m  <= 1'b0;
			mem_to_reg_m <= 1'b0;
			mem_write_m  <= 1'b0;
		end else begin
			write_reg_m  <= write_reg_e;
			reg_write_m  <= reg_write_e;
			mem_to_reg_m <= mem_to_reg_e;
			mem_write_m  <= mem_write_e;
		end
	end

	always_ff @(posedge clk) begin
		alu_result_m <= alu_y;
		store_data_m <= src_b;
	end

endmodule

`default_nettype wire

/* logic/mips_hazard.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_hazard (
	input  wire  [mips_pkg::REG_ADDR_W-1:0] rs_d,
	input  wire  [mips_pkg::REG_ADDR_W-1:0] rt_d,
	input  wire                             branch_d,
	input  wire  [mips_pkg::REG_ADDR_W-1:0] rs_e,
	input  wire  [mips_pkg::REG_ADDR_W-1:0] rt_e,
	input  wire  [mips_pkg::REG_ADDR_W-1:0] write_reg_e,
	input  wire                             reg_write_e,
	input  wire                             mem_to_reg_e,
	input  wire  [mips_pkg::REG_ADDR_W-1:0] write_reg_m,
	input  wire                             reg_write_m,
	input  wire                             mem_to_reg_m,
	input  wire  [mips_pkg::REG_ADDR_W-1:0] wb_addr,
	input  wire                             wb_en,
	output logic [1:0]                      fwd_a_e,
	output logic [1:0]                      fwd_b_e,
	output logic                            fwd_a_d,
	output logic                            fwd_b_d,
	output logic                            stall,
	output logic                            flush_e
);
	import mips_pkg::*;

	logic lw_stall;
	logic branch_stall;

	// ------------------------------
	// Forwarding
	// ------------------------------
	// Memory stage is newer, so it beats writeback
	// reg_write is already low for a $0 destination
	assign fwd_a_e = (reg_write_m && write_reg_m == rs_e) ? FWD_MEM :
		(wb_en && wb_addr == rs_e) ? FWD_WB : FWD_REG;
	assign fwd_b_e = (reg_write_m && write_reg_m == rt_e) ? FWD_MEM :
		(wb_en && wb_addr == rt_e) ? FWD_WB : FWD_REG;

	// Branch compare only takes an ALU result from memory
	assign fwd_a_d = reg_write_m && !mem_to_reg_m && write_reg_m == rs_d;
	assign fwd_b_d = reg_write_m && !mem_to_reg_m && write_reg_m == rt_d;

	// ------------------------------
	// Stalls
	// ------------------------------
	// Load in execute feeding the next instruction
	assign lw_stall = mem_to_reg_e && reg_write_e &&
		(write_reg_e == rs_d || write_reg_e == rt_d);

	// Branch waits on any producer in execute, or a load in memory
	assign branch_stall = branch_d &&
		((reg_write_e && (write_reg_e == rs_d || write_reg_e == rt_d)) ||
		(reg_write_m && mem_to_reg_m && (write_reg_m == rs_d || write_reg_m == rt_d)));

	assign stall   = lw_stall || branch_stall;
	// Held instruction leaves a bubble behind it
	assign flush_e = stall;

endmodule

`default_nettype wire

/* logic/mips_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
	input  wire                               clk,
	input  wire                               arst_n,
	input  wire mips_pkg::instr_u             instr_d,
	input  wire  [mips_pkg::DATA_W-1:0]       pc_plus4_d,
	input  wire                               stall,
	input  wire                               flush_e,
	input  wire                               fwd_a_d,
	input  wire                               fwd_b_d,
	input  wire  [mips_pkg::DATA_W-1:0]       alu_result_m,
	input  wire                               wb_en,
	input  wire  [mips_pkg::REG_ADDR_W-1:0]   wb_addr,
	input  wire  [mips_pkg::DATA_W-1:0]       wb_data,
	output logic                              redirect,
	output logic [mips_pkg::DATA_W-1:0]       redirect_pc,
	output logic [mips_pkg::REG_ADDR_W-1:0]   rs_d,
	output logic [mips_pkg::REG_ADDR_W-1:0]   rt_d,
	output logic                              branch_d,
	output logic [mips_pkg::REG_ADDR_W-1:0]   rs_e,
	output logic [mips_pkg::REG_ADDR_W-1:0]   rt_e,
	output logic [mips_pkg::REG_ADDR_W-1:0]   rd_e,
	output logic [mips_pkg::DATA_W-1:0]       read_a_e,
	output logic [mips_pkg::DATA_W-1:0]       read_b_e,
	output logic [mips_pkg::DATA_W-1:0]       imm_e,
	output logic [2:0]                        alu_op_e,
	output logic                              alu_src_e,
	output logic                              reg_dst_e,
	output logic                              reg_write_e,
	output logic                              mem_to_reg_e,
	output logic                              mem_write_e
);
	import mips_pkg::*;

	logic [DATA_W-1:0]     regs [NUM_REGS];
	logic [DATA_W-1:0]     read_a, read_b;
	logic [DATA_W-1:0]     cmp_a, cmp_b;
	logic [DATA_W-1:0]     imm_d;
	logic [REG_ADDR_W-1:0] dest_d;
	logic [2:0]            alu_op_d;
	logic                  alu_src_d;
	logic                  reg_dst_d;
	logic                  reg_write_d;
	logic                  mem_to_reg_d;
	logic                  mem_write_d;
	logic                  jump_d;
	logic                  taken_d;

	assign rs_d  = instr_d.r.rs;
	assign rt_d  = instr_d.r.rt;
	assign imm_d = {{(DATA_W-16){instr_d.i.imm[15]}}, instr_d.i.imm};

	// ------------------------------
	// Control
	// ------------------------------
	always_comb begin
		alu_op_d     = ALU_ADD;
		alu_src_d    = 1'b0;
		reg_dst_d    = 1'b0;
		reg_write_d  = 1'b0;
		mem_to_reg_d = 1'b0;
		mem_write_d  = 1'b0;
		branch_d     = 1'b0;
		jump_d       = 1'b0;
		case (instr_d.r.opcode)
			OP_RTYPE: begin
				reg_dst_d   = 1'b1;
				reg_write_d = 1'b1;
				case (instr_d.r.funct)
					FN_ADD:  alu_op_d = ALU_ADD;
					FN_SUB:  alu_op_d = ALU_SUB;
					FN_AND:  alu_op_d = ALU_AND;
					FN_OR:   alu_op_d = ALU_OR;
					FN_SLT:  alu_op_d = ALU_SLT;
					// Unknown funct retires nothing
					default: reg_write_d = 1'b0;
				endcase
			end
			OP_ADDI: begin
				alu_src_d   = 1'b1;
				reg_write_d = 1'b1;
			end
			OP_LW: begin
				alu_src_d    = 1'b1;
				reg_write_d  = 1'b1;
				mem_to_reg_d = 1'b1;
			end
			OP_SW: begin
				alu_src_d   = 1'b1;
				mem_write_d = 1'b1;
			end
			OP_BEQ:  branch_d = 1'b1;
			OP_J:    jump_d   = 1'b1;
			default: ;
		endcase
	end

	// Destination as execute will pick it
	// A $0 destination never writes
	assign dest_d = reg_dst_d ? instr_d.r.rd : instr_d.r.rt;

	// ------------------------------
	// Register file
	// ------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// Write-through so the writeback value wins in the same cycle
	assign read_a = (wb_en && wb_addr == rs_d) ? wb_data : regs[rs_d];
	assign read_b = (wb_en && wb_addr == rt_d) ? wb_data : regs[rt_d];

	// Branch compare takes the memory-stage result when forwarded
	assign cmp_a   = fwd_a_d ? alu_result_m : read_a;
	assign cmp_b   = fwd_b_d ? alu_result_m : read_b;
	assign taken_d = branch_d && (cmp_a == cmp_b);

	// Held back while the operands are not ready
	assign redirect    = (taken_d || jump_d) && !stall;
	assign redirect_pc = jump_d
		? {pc_plus4_d[DATA_W-1:28], instr_d.i.rs, instr_d.i.rt, instr_d.i.imm, 2'b00}
		: pc_plus4_d + {imm_d[DATA_W-3:0], 2'b00};

	// ------------------------------
	// Decode/execute register
	// ------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			alu_op_e     <= ALU_ADD;
			alu_src_e    <= 1'b0;
			reg_dst_e    <= 1'b0;
			reg_write_e  <= 1'b0;
			mem_to_reg_e <= 1'b0;
			mem_write_e  <= 1'b0;
		end else if (flush_e) begin
			// Bubble behind the held instruction
			alu_op_e     <= ALU_ADD;
			alu_src_e    <= 1'b0;
			reg_dst_e    <= 1'b0;
			reg_write_e  <= 1'b0;
			mem_to_reg_e <= 1'b0;
			mem_write_e  <= 1'b0;
		end else begin
			alu_op_e     <= alu_op_d;
			alu_src_e    <= alu_src_d;
			reg_dst_e    <= reg_dst_d;
			reg_write_e  <= reg_write_d && (dest_d != '0);
			mem_to_reg_e <= mem_to_reg_d;
			mem_write_e  <= mem_write_d;
		end
	end

	always_ff @(posedge clk) begin
		rs_e     <= rs_d;
		rt_e     <= rt_d;
		rd_e     <= instr_d.r.rd;
		read_a_e <= read_a;
		read_b_e <= read_b;
		imm_e    <= imm_d;
	end

endmodule

`default_nettype wire

/* logic/mips_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_fetch #(
	parameter int IMEM_DEPTH = 64
) (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire                           load_en,
	input  wire  [mips_pkg::DATA_W-1:0]   load_data,
	input  wire                           stall,
	input  wire                           redirect,
	input  wire  [mips_pkg::DATA_W-1:0]   redirect_pc,
	output mips_pkg::instr_u              instr_d,
	output logic [mips_pkg::DATA_W-1:0]   pc_plus4_d
);
	import mips_pkg::*;

	// Word index width into the instruction store
	localparam int IA_W = $clog2(IMEM_DEPTH);

	logic [DATA_W-1:0] pc;
	logic [DATA_W-1:0] pc_plus4;
	logic [IA_W-1:0]   load_ptr;
	instr_u            imem [IMEM_DEPTH];
	instr_u            instr_f;

	assign pc_plus4 = pc + DATA_W'(4);
	// Asynchronous read, word addressed
	assign instr_f  = imem[pc[IA_W+1:2]];

	// ------------------------------
	// Program counter
	// ------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (load_en) begin
			// Parked at the reset vector while loading
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (!stall) begin
			pc <= pc_plus4;
		end
	end

	// Load pointer walks up from word 0
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			load_ptr <= '0;
		end else if (load_en) begin
			load_ptr <= load_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load_en) begin
			imem[load_ptr] <= load_data;
		end
	end

	// ------------------------------
	// Fetch/decode register
	// ------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			instr_d    <= '0;
			pc_plus4_d <= '0;
		end else if (load_en || redirect) begin
			// All-zero word decodes as a no-op
			instr_d    <= '0;
			pc_plus4_d <= '0;
		end else if (!stall) begin
			instr_d    <= instr_f;
			pc_plus4_d <= pc_plus4;
		end
	end

endmodule

`default_nettype wire

/* logic/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	// ------------------------------
	// Widths
	// ------------------------------
	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	// ------------------------------
	// Opcodes and R-type functs
	// ------------------------------
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_J     = 6'h02;

	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// ALU operation, set in decode and used in execute
	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR  = 3'd3;
	localparam logic [2:0] ALU_SLT = 3'd4;

	// Execute operand source
	localparam logic [1:0] FWD_REG = 2'd0;
	// Result being written back
	localparam logic [1:0] FWD_WB  = 2'd1;
	// ALU result sitting in the memory stage
	localparam logic [1:0] FWD_MEM = 2'd2;

	// ------------------------------
	// Instruction word
	// ------------------------------
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_view_t;

	// J target is {rs, rt, imm} of this view
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_view_t;

	typedef union packed {
		r_view_t r;
		i_view_t i;
	} instr_u;

endpackage

`default_nettype wire
